/* design/host_chan_pkg.sv */
/*
 * Shared definitions for the host channel subsystem
 * Widths, port and credit counts, MMIO register map,
 * request and response structs, start command union
 */

package host_chan_pkg;

    // ========================================
    // Sizes
    // ========================================

    localparam int NUM_AFU_PORTS = 4;
    localparam int VCHAN_W = 2;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    // Burst length minus one, 1 to 16 beats
    localparam int LEN_W = 4;
    localparam int HOST_REQ_CREDITS = 8;
    localparam int CREDIT_W = 4;
    localparam int CNT_W = 32;
    localparam int BURSTS_W = 16;
    localparam int MMIO_ADDR_W = 6;

    typedef logic [VCHAN_W-1:0] t_vchan;
    typedef logic [CREDIT_W-1:0] t_credit;

    localparam t_credit CREDIT_INIT = t_credit'(HOST_REQ_CREDITS);

    // ========================================
    // MMIO register map
    // ========================================

    // Write starts a run, read returns busy
    localparam logic [MMIO_ADDR_W-1:0] REG_CTRL = 6'h00;
    localparam logic [MMIO_ADDR_W-1:0] REG_CHECKSUM = 6'h08;
    localparam logic [MMIO_ADDR_W-1:0] REG_REQ_CNT = 6'h10;
    localparam logic [MMIO_ADDR_W-1:0] REG_BEAT_CNT = 6'h18;
    // Instance number of the port
    localparam logic [MMIO_ADDR_W-1:0] REG_ID = 6'h20;

    // ========================================
    // Channel types
    // ========================================

    typedef struct packed {
        logic valid;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0] len;
    } t_rd_req;

    typedef struct packed {
        logic valid;
        t_vchan vchan;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0] len;
    } t_host_rd_req;

    typedef struct packed {
        logic valid;
        logic [DATA_W-1:0] data;
        logic last;
    } t_rd_rsp;

    typedef struct packed {
        logic valid;
        t_vchan vchan;
        logic [DATA_W-1:0] data;
        logic last;
    } t_host_rd_rsp;

    typedef struct packed {
        logic valid;
        logic write;
        t_vchan vchan;
        logic [MMIO_ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } t_mmio_req;

    typedef struct packed {
        logic valid;
        t_vchan vchan;
        logic [DATA_W-1:0] rdata;
    } t_mmio_rsp;

    // Per-AFU MMIO, tag already stripped
    typedef struct packed {
        logic valid;
        logic write;
        logic [MMIO_ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } t_afu_mmio_req;

    typedef struct packed {
        logic valid;
        logic [DATA_W-1:0] rdata;
    } t_afu_mmio_rsp;

    // Start command, start_addr in the low bits
    typedef struct packed {
        logic [DATA_W-ADDR_W-BURSTS_W-LEN_W-1:0] pad;
        logic [LEN_W-1:0] burst_len;
        logic [BURSTS_W-1:0] num_bursts;
        logic [ADDR_W-1:0] start_addr;
    } t_start_cmd;

    // One MMIO write word, seen raw or as a command
    typedef union packed {
        logic [DATA_W-1:0] raw;
        t_start_cmd cmd;
    } t_ctrl_word;

    typedef struct packed {
        logic [CNT_W-1:0] req_cnt;
        logic [CNT_W-1:0] beats_req;
        logic [CNT_W-1:0] beats_rsp;
        logic [CNT_W-1:0] beats_outstanding;
    } t_read_events;

endpackage

/* design/host_mem_vchan_mux.sv */
/*
 * Host memory vchan multiplexer
 * Round-robin arbitration of AFU read requests onto the
 * credited host request path, read data steered back by vchan
 */

module host_mem_vchan_mux
(
    input  logic clk,
    input  logic rst,

    input  host_chan_pkg::t_rd_req afu_rd_req [host_chan_pkg::NUM_AFU_PORTS],
    output logic afu_rd_grant [host_chan_pkg::NUM_AFU_PORTS],
    output host_chan_pkg::t_rd_rsp afu_rd_rsp [host_chan_pkg::NUM_AFU_PORTS],

    output host_chan_pkg::t_host_rd_req host_rd_req,
    input  logic host_req_credit,
    input  host_chan_pkg::t_host_rd_rsp host_rd_rsp
);

    // ========================================
    // Credits and arbitration
    // ========================================

    host_chan_pkg::t_credit credit_cnt;
    // Last port that won
    host_chan_pkg::t_vchan rr_ptr;
    host_chan_pkg::t_vchan cand;
    host_chan_pkg::t_vchan winner;
    logic found;
    logic send;

    // Search starts one past the last winner
    always_comb
    begin
        winner = rr_ptr;
        found = 1'b0;
        cand = rr_ptr;
        for (int i = 1; i <= host_chan_pkg::NUM_AFU_PORTS; i++)
        begin
            cand = host_chan_pkg::t_vchan'((int'(rr_ptr) + i) % host_chan_pkg::NUM_AFU_PORTS);
            if (!found && afu_rd_req[cand].valid)
            begin
                winner = cand;
                found = 1'b1;
            end
        end
    end

    // Nothing leaves without a credit in hand
    assign send = found && (credit_cnt != '0);

    always_comb
    begin
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
        begin
            afu_rd_grant[p] = send && (int'(winner) == p);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            credit_cnt <= host_chan_pkg::CREDIT_INIT;
            rr_ptr <= '0;
        end
        else
        begin
            // Send and credit return can land in the same cycle
            case ({send, host_req_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase

            if (send)
            begin
                rr_ptr <= winner;
            end
        end
    end

    // Winner goes to the host one cycle after its grant
    always_ff @(posedge clk)
    begin
        host_rd_req.valid <= send;
        host_rd_req.vchan <= winner;
        host_rd_req.addr <= afu_rd_req[winner].addr;
        host_rd_req.len <= afu_rd_req[winner].len;
        if (rst)
        begin
            host_rd_req.valid <= 1'b0;
        end
    end

    // ========================================
    // Read data steering
    // ========================================

    // Exactly one port sees each beat, one cycle later
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
        begin
            afu_rd_rsp[p].valid <= host_rd_rsp.valid && (int'(host_rd_rsp.vchan) == p);
            afu_rd_rsp[p].data <= host_rd_rsp.data;
            afu_rd_rsp[p].last <= host_rd_rsp.last;
            if (rst)
            begin
                afu_rd_rsp[p].valid <= 1'b0;
            end
        end
    end

endmodule

/* design/mmio_vchan_demux.sv */
/*
 * MMIO vchan demultiplexer
 * Tagged host requests routed to one AFU, responses merged back
 */

module mmio_vchan_demux
(
    input  logic clk,
    input  logic rst,

    input  host_chan_pkg::t_mmio_req host_mmio_req,
    output host_chan_pkg::t_mmio_rsp host_mmio_rsp,

    output host_chan_pkg::t_afu_mmio_req afu_mmio_req [host_chan_pkg::NUM_AFU_PORTS],
    input  host_chan_pkg::t_afu_mmio_rsp afu_mmio_rsp [host_chan_pkg::NUM_AFU_PORTS]
);

    // Tag of the one request in flight
    host_chan_pkg::t_vchan req_vchan;
    logic rsp_any;
    logic [host_chan_pkg::DATA_W-1:0] rsp_data;

    // ========================================
    // Request routing
    // ========================================

    always_ff @(posedge clk)
    begin
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
        begin
            afu_mmio_req[p].valid <= host_mmio_req.valid &&
                                     (int'(host_mmio_req.vchan) == p);
            afu_mmio_req[p].write <= host_mmio_req.write;
            afu_mmio_req[p].addr <= host_mmio_req.addr;
            afu_mmio_req[p].wdata <= host_mmio_req.wdata;
            if (rst)
            begin
                afu_mmio_req[p].valid <= 1'b0;
            end
        end

        if (host_mmio_req.valid)
        begin
            req_vchan <= host_mmio_req.vchan;
        end
    end

    // ========================================
    // Response merge
    // ========================================

    // Host keeps one request outstanding, so at most one AFU answers
    always_comb
    begin
        rsp_any = 1'b0;
        rsp_data = '0;
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
        begin
            if (afu_mmio_rsp[p].valid)
            begin
                rsp_any = 1'b1;
                rsp_data = afu_mmio_rsp[p].rdata;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        host_mmio_rsp.valid <= rsp_any;
        host_mmio_rsp.vchan <= req_vchan;
        host_mmio_rsp.rdata <= rsp_data;
        if (rst)
        begin
            host_mmio_rsp.valid <= 1'b0;
        end
    end

endmodule

/* design/read_event_counter.sv */
/*
 * Read event counter for one AFU
 * Requests, requested beats, returned beats, beats outstanding
 */

module read_event_counter
(
    input  logic clk,
    input  logic rst,

    // Request accepted by the mux
    input  logic req_fire,
    input  logic [host_chan_pkg::LEN_W-1:0] req_len,
    // One beat returned
    input  logic rsp_fire,

    output host_chan_pkg::t_read_events events
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            events <= '0;
        end
        else
        begin
            if (req_fire)
            begin
                events.req_cnt <= events.req_cnt + 1'b1;
                // Length field is beats minus one
                events.beats_req <= events.beats_req + req_len + 1'b1;
            end

            if (rsp_fire)
            begin
                events.beats_rsp <= events.beats_rsp + 1'b1;
            end

            // Both at once: len+1 in, one out
            if (req_fire && rsp_fire)
            begin
                events.beats_outstanding <= events.beats_outstanding + req_len;
            end
            else if (req_fire)
            begin
                events.beats_outstanding <= events.beats_outstanding + req_len + 1'b1;
            end
            else if (rsp_fire)
            begin
                events.beats_outstanding <= events.beats_outstanding - 1'b1;
            end
        end
    end

endmodule

/* design/afu_read_engine.sv */
/*
 * Per-AFU read engine
 * MMIO CSR block, burst read issue and running checksum
 */

module afu_read_engine
#(
    parameter int VCHAN_NUMBER = 0
)
(
    input  logic clk,
    input  logic rst,

    input  host_chan_pkg::t_afu_mmio_req mmio_req,
    output host_chan_pkg::t_afu_mmio_rsp mmio_rsp,

    output host_chan_pkg::t_rd_req rd_req,
    input  logic rd_grant,
    input  host_chan_pkg::t_rd_rsp rd_rsp,

    input  host_chan_pkg::t_read_events events
);

    host_chan_pkg::t_ctrl_word ctrl;
    logic start;
    logic busy;
    logic [host_chan_pkg::DATA_W-1:0] checksum;
    // Bursts not yet granted
    logic [host_chan_pkg::BURSTS_W-1:0] issue_left;
    // Bursts whose last beat has not come back
    logic [host_chan_pkg::BURSTS_W-1:0] bursts_pending;
    logic [host_chan_pkg::ADDR_W-1:0] burst_bytes;
    logic [host_chan_pkg::DATA_W-1:0] rd_word;

    // ========================================
    // Command decode
    // ========================================

    assign ctrl.raw = mmio_req.wdata;

    // Writes while busy are dropped
    assign start = mmio_req.valid && mmio_req.write &&
                   (mmio_req.addr == host_chan_pkg::REG_CTRL) && !busy;

    // 8 bytes per beat
    assign burst_bytes = {rd_req.len, 3'b000} + 8;

    // ========================================
    // Burst issue and checksum
    // ========================================

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rd_req.addr <= ctrl.cmd.start_addr;
            rd_req.len <= ctrl.cmd.burst_len;
        end
        else if (rd_grant)
        begin
            rd_req.addr <= rd_req.addr + burst_bytes;
        end

        if (rst)
        begin
            busy <= 1'b0;
            rd_req.valid <= 1'b0;
            issue_left <= '0;
            bursts_pending <= '0;
            checksum <= '0;
        end
        else if (start)
        begin
            busy <= (ctrl.cmd.num_bursts != '0);
            rd_req.valid <= (ctrl.cmd.num_bursts != '0);
            issue_left <= ctrl.cmd.num_bursts;
            bursts_pending <= ctrl.cmd.num_bursts;
            checksum <= '0;
        end
        else
        begin
            // Next burst is offered right after a grant
            if (rd_grant)
            begin
                issue_left <= issue_left - 1'b1;
                if (issue_left == 1)
                begin
                    rd_req.valid <= 1'b0;
                end
            end

            if (rd_rsp.valid)
            begin
                checksum <= checksum + rd_rsp.data;
                // Idle once the final beat is summed
                if (rd_rsp.last)
                begin
                    bursts_pending <= bursts_pending - 1'b1;
                    if (bursts_pending == 1)
                    begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // ========================================
    // CSR read
    // ========================================

    always_comb
    begin
        rd_word = '0;
        case (mmio_req.addr)
            host_chan_pkg::REG_CTRL: rd_word[0] = busy;
            host_chan_pkg::REG_CHECKSUM: rd_word = checksum;
            host_chan_pkg::REG_REQ_CNT: rd_word[host_chan_pkg::CNT_W-1:0] = events.req_cnt;
            host_chan_pkg::REG_BEAT_CNT: rd_word[host_chan_pkg::CNT_W-1:0] = events.beats_rsp;
            host_chan_pkg::REG_ID: rd_word = VCHAN_NUMBER;
            default: rd_word = '0;
        endcase
    end

    // Every request is answered, writes included
    always_ff @(posedge clk)
    begin
        mmio_rsp.valid <= mmio_req.valid;
        mmio_rsp.rdata <= rd_word;
        if (rst)
        begin
            mmio_rsp.valid <= 1'b0;
        end
    end

endmodule

/* design/host_chan_afu_top.sv */
/*
 * Host channel subsystem top
 * Memory and MMIO vchan demultiplexers, per port an
 * event counter and a read engine AFU
 */

module host_chan_afu_top
(
    input  logic clk,
    input  logic rst,

    output host_chan_pkg::t_host_rd_req host_rd_req,
    input  logic host_req_credit,
    input  host_chan_pkg::t_host_rd_rsp host_rd_rsp,

    input  host_chan_pkg::t_mmio_req host_mmio_req,
    output host_chan_pkg::t_mmio_rsp host_mmio_rsp
);

    // ========================================
    // Per-port channels
    // ========================================

    host_chan_pkg::t_rd_req afu_rd_req [host_chan_pkg::NUM_AFU_PORTS];
    logic afu_rd_grant [host_chan_pkg::NUM_AFU_PORTS];
    host_chan_pkg::t_rd_rsp afu_rd_rsp [host_chan_pkg::NUM_AFU_PORTS];
    host_chan_pkg::t_afu_mmio_req afu_mmio_req [host_chan_pkg::NUM_AFU_PORTS];
    host_chan_pkg::t_afu_mmio_rsp afu_mmio_rsp [host_chan_pkg::NUM_AFU_PORTS];
    host_chan_pkg::t_read_events events [host_chan_pkg::NUM_AFU_PORTS];

    // Vchan number is the port index
    host_mem_vchan_mux host_mem_mux
    (
        .clk(clk),
        .rst(rst),
        .afu_rd_req(afu_rd_req),
        .afu_rd_grant(afu_rd_grant),
        .afu_rd_rsp(afu_rd_rsp),
        .host_rd_req(host_rd_req),
        .host_req_credit(host_req_credit),
        .host_rd_rsp(host_rd_rsp)
    );

    mmio_vchan_demux mmio64_demux
    (
        .clk(clk),
        .rst(rst),
        .host_mmio_req(host_mmio_req),
        .host_mmio_rsp(host_mmio_rsp),
        .afu_mmio_req(afu_mmio_req),
        .afu_mmio_rsp(afu_mmio_rsp)
    );

    // ========================================
    // One counter and one AFU per port
    // ========================================

    for (genvar p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
    begin : port
        // Watch the AFU side of the mux
        read_event_counter ev
        (
            .clk(clk),
            .rst(rst),
            .req_fire(afu_rd_grant[p]),
            .req_len(afu_rd_req[p].len),
            .rsp_fire(afu_rd_rsp[p].valid),
            .events(events[p])
        );

        afu_read_engine #(.VCHAN_NUMBER(p)) afu_impl
        (
            .clk(clk),
            .rst(rst),
            .mmio_req(afu_mmio_req[p]),
            .mmio_rsp(afu_mmio_rsp[p]),
            .rd_req(afu_rd_req[p]),
            .rd_grant(afu_rd_grant[p]),
            .rd_rsp(afu_rd_rsp[p]),
            .events(events[p])
        );
    end

endmodule

/* verification/host_chan_afu_asserts.sv */
/*
 * Concurrent checks on the host memory vchan mux
 * Credit use, one-hot read data steering, grant legality, reset state
 */

module host_chan_afu_asserts
(
    input  logic clk,
    input  logic rst,
    input  logic host_req_credit,
    input  host_chan_pkg::t_rd_req afu_rd_req [host_chan_pkg::NUM_AFU_PORTS],
    input  logic afu_rd_grant [host_chan_pkg::NUM_AFU_PORTS],
    input  host_chan_pkg::t_rd_rsp afu_rd_rsp [host_chan_pkg::NUM_AFU_PORTS],
    input  host_chan_pkg::t_host_rd_req host_rd_req
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed properties
    int fail_cnt = 0;
    // Credits handed out by the host and not yet used by a request
    int credits_left;
    logic bad_grant;
    int rsp_valids;

    // Credit balance as seen on the host ports
    always @(posedge clk)
    begin
        if (rst)
            credits_left <= host_chan_pkg::HOST_REQ_CREDITS;
        else
            credits_left <= credits_left - int'(host_rd_req.valid) + int'(host_req_credit);
    end

    always_comb
    begin
        bad_grant = 1'b0;
        rsp_valids = 0;
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
        begin
            // Grant without a request behind it
            bad_grant = bad_grant | (afu_rd_grant[p] & ~afu_rd_req[p].valid);
            rsp_valids = rsp_valids + int'(afu_rd_rsp[p].valid);
        end
    end

    // ========================================
    // Properties
    // ========================================

    // Every request on the host side needs a credit in the balance
    credit_held: assert property (@(posedge clk) disable iff (rst)
        host_rd_req.valid |-> (credits_left > 0))
        else
        begin
            fail_cnt++;
            $error("request sent with zero credits");
        end

    rsp_one_hot: assert property (@(posedge clk) disable iff (rst) rsp_valids <= 1)
        else
        begin
            fail_cnt++;
            $error("read data steered to more than one port");
        end

    grant_legal: assert property (@(posedge clk) disable iff (rst) !bad_grant)
        else
        begin
            fail_cnt++;
            $error("grant to a port without a valid request");
        end

    // Reset clears the host request register
    req_reset: assert property (@(posedge clk) rst |=> !host_rd_req.valid)
        else
        begin
            fail_cnt++;
            $error("host request valid after reset");
        end

endmodule

bind host_mem_vchan_mux host_chan_afu_asserts mux_asserts
(
    .clk(clk),
    .rst(rst),
    .host_req_credit(host_req_credit),
    .afu_rd_req(afu_rd_req),
    .afu_rd_grant(afu_rd_grant),
    .afu_rd_rsp(afu_rd_rsp),
    .host_rd_req(host_rd_req)
);

/* verification/host_chan_afu_tb.sv */
/*
 * Testbench for the host channel subsystem
 * Clock, reset, host memory and MMIO model, reference functions,
 * compare tasks and the test sequence
 */

module host_chan_afu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic rst;
    host_chan_pkg::t_host_rd_req host_rd_req;
    logic host_req_credit;
    host_chan_pkg::t_host_rd_rsp host_rd_rsp;
    host_chan_pkg::t_mmio_req host_mmio_req;
    host_chan_pkg::t_mmio_rsp host_mmio_rsp;

    // Host model state
    host_chan_pkg::t_host_rd_req pending_q[$];
    host_chan_pkg::t_host_rd_req req_log[$];
    host_chan_pkg::t_host_rd_req cur;
    host_chan_pkg::t_host_rd_rsp beat;
    int beat_idx;
    int gap_left;
    int credit_owed;
    int outstanding;
    logic hold_credits;
    logic [31:0] lcg_state = 32'h400f_ecc0;
    int wait_cycles;

    // Expected counter values since reset
    int req_total [host_chan_pkg::NUM_AFU_PORTS];
    int beat_total [host_chan_pkg::NUM_AFU_PORTS];
    host_chan_pkg::t_start_cmd cmds [host_chan_pkg::NUM_AFU_PORTS];

    host_chan_afu_top dut
    (
        .clk(clk),
        .rst(rst),
        .host_rd_req(host_rd_req),
        .host_req_credit(host_req_credit),
        .host_rd_rsp(host_rd_rsp),
        .host_mmio_req(host_mmio_req),
        .host_mmio_rsp(host_mmio_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // Reference model and reporting
    // ========================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Host memory contents mixed from the byte address
    function automatic logic [63:0] mem_word(logic [31:0] addr);
        logic [63:0] w;
        w = {32'h0, addr};
        return (w * 64'h9e37_79b9_7f4a_7c15) ^ 64'hc3a5_c85c_97cb_3127;
    endfunction

    // Bursts of one command are contiguous
    function automatic logic [63:0] expected_checksum(host_chan_pkg::t_start_cmd cmd);
        logic [63:0] sum;
        logic [31:0] addr;
        int beats;
        sum = '0;
        addr = cmd.start_addr;
        beats = int'(cmd.num_bursts) * (int'(cmd.burst_len) + 1);
        for (int i = 0; i < beats; i++)
        begin
            sum = sum + mem_word(addr);
            addr = addr + 32'd8;
        end
        return sum;
    endfunction

    function automatic host_chan_pkg::t_start_cmd make_cmd(logic [31:0] addr, int bursts,
                                                           int len);
        host_chan_pkg::t_start_cmd cmd;
        cmd = '0;
        cmd.start_addr = addr;
        cmd.num_bursts = bursts[host_chan_pkg::BURSTS_W-1:0];
        cmd.burst_len = len[host_chan_pkg::LEN_W-1:0];
        return cmd;
    endfunction

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_mmio_rsp(string name, host_chan_pkg::t_mmio_rsp got,
                                    host_chan_pkg::t_mmio_rsp exp);
        if (got !== exp)
            report_error($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_host_req(string name, host_chan_pkg::t_host_rd_req got,
                                    host_chan_pkg::t_host_rd_req exp);
        if (got !== exp)
            report_error($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    // Data and last only matter on a valid beat
    task automatic compare_rd_data(string name, host_chan_pkg::t_rd_rsp got,
                                   host_chan_pkg::t_rd_rsp exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.data !== exp.data || got.last !== exp.last)))
            report_error($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_events(string name, host_chan_pkg::t_read_events got,
                                  host_chan_pkg::t_read_events exp);
        if (got !== exp)
            report_error($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    // ========================================
    // Host memory model
    // ========================================

    always @(posedge clk)
    begin
        host_rd_rsp.valid <= 1'b0;
        host_req_credit <= 1'b0;
        if (rst)
        begin
            pending_q.delete();
            beat_idx = 0;
            gap_left = 0;
            credit_owed = 0;
            outstanding = 0;
        end
        else
        begin
            if (host_rd_req.valid)
            begin
                pending_q.push_back(host_rd_req);
                req_log.push_back(host_rd_req);
                outstanding++;
                if (outstanding > host_chan_pkg::HOST_REQ_CREDITS)
                    report_error("more host requests outstanding than credits");
            end

            // Head burst returns one beat per cycle with random gaps
            if (gap_left > 0)
                gap_left--;
            else if (pending_q.size() > 0)
            begin
                cur = pending_q[0];
                beat.valid = 1'b1;
                beat.vchan = cur.vchan;
                beat.data = mem_word(cur.addr + {beat_idx[28:0], 3'b000});
                beat.last = (beat_idx == int'(cur.len));
                host_rd_rsp <= beat;
                if (beat.last)
                begin
                    void'(pending_q.pop_front());
                    beat_idx = 0;
                    credit_owed++;
                end
                else
                    beat_idx++;
                gap_left = int'((lcg_next() >> 24) % 3);
            end

            // Credits trickle back one per cycle unless held
            if (credit_owed > 0 && !hold_credits)
            begin
                host_req_credit <= 1'b1;
                credit_owed--;
                outstanding--;
            end
        end
    end

    // Each host beat shows up on exactly its own port one cycle later
    for (genvar p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
    begin : rsp_check
        host_chan_pkg::t_host_rd_rsp seen = '0;
        host_chan_pkg::t_rd_rsp exp;

        always @(posedge clk)
        begin
            exp.valid = seen.valid && (int'(seen.vchan) == p);
            exp.data = seen.data;
            exp.last = seen.last;
            if (!rst)
                compare_rd_data($sformatf("afu_rd_rsp[%0d]", p), dut.afu_rd_rsp[p], exp);
            seen <= host_rd_rsp;
        end
    end

    // ========================================
    // MMIO access
    // ========================================

    // Called right after a rising edge
    task automatic mmio_access(logic write, int port, logic [5:0] addr, logic [63:0] wdata,
                               output host_chan_pkg::t_mmio_rsp rsp);
        host_chan_pkg::t_mmio_req req;
        int cycles;
        req.valid = 1'b1;
        req.write = write;
        req.vchan = host_chan_pkg::t_vchan'(port);
        req.addr = addr;
        req.wdata = wdata;
        host_mmio_req <= req;
        @(posedge clk);
        host_mmio_req.valid <= 1'b0;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
            if (cycles > 20)
                report_error($sformatf("no MMIO response from port %0d", port));
        end
        while (!host_mmio_rsp.valid);
        rsp = host_mmio_rsp;
        // Demux in, CSR, demux out
        if (cycles != 3)
            report_error($sformatf("MMIO response took %0d cycles instead of 3", cycles));
    endtask

    task automatic mmio_write(int port, logic [5:0] addr, logic [63:0] wdata);
        host_chan_pkg::t_mmio_rsp rsp;
        mmio_access(1'b1, port, addr, wdata, rsp);
        if (rsp.vchan !== host_chan_pkg::t_vchan'(port))
            report_error($sformatf("Fail host_mmio_rsp.vchan got %h expected %h",
                                   rsp.vchan, port[1:0]));
    endtask

    task automatic read_and_compare(int port, logic [5:0] addr, logic [63:0] exp_data);
        host_chan_pkg::t_mmio_rsp rsp;
        host_chan_pkg::t_mmio_rsp exp;
        mmio_access(1'b0, port, addr, '0, rsp);
        exp.valid = 1'b1;
        exp.vchan = host_chan_pkg::t_vchan'(port);
        exp.rdata = exp_data;
        compare_mmio_rsp("host_mmio_rsp", rsp, exp);
    endtask

    task automatic start_run(int port, host_chan_pkg::t_start_cmd cmd);
        cmds[port] = cmd;
        req_total[port] += int'(cmd.num_bursts);
        beat_total[port] += int'(cmd.num_bursts) * (int'(cmd.burst_len) + 1);
        mmio_write(port, host_chan_pkg::REG_CTRL, cmd);
    endtask

    // Poll busy until the run is done, then check results
    task automatic check_port(int port);
        host_chan_pkg::t_mmio_rsp rsp;
        host_chan_pkg::t_read_events exp_ev;
        int polls;
        polls = 0;
        do
        begin
            mmio_access(1'b0, port, host_chan_pkg::REG_CTRL, '0, rsp);
            polls++;
            if (polls > 500)
                report_error($sformatf("port %0d never went idle", port));
        end
        while (rsp.rdata[0] !== 1'b0);
        read_and_compare(port, host_chan_pkg::REG_CHECKSUM, expected_checksum(cmds[port]));
        read_and_compare(port, host_chan_pkg::REG_REQ_CNT, 64'(req_total[port]));
        read_and_compare(port, host_chan_pkg::REG_BEAT_CNT, 64'(beat_total[port]));
        // Idle port has every requested beat back
        exp_ev.req_cnt = 32'(req_total[port]);
        exp_ev.beats_req = 32'(beat_total[port]);
        exp_ev.beats_rsp = 32'(beat_total[port]);
        exp_ev.beats_outstanding = '0;
        compare_events($sformatf("events[%0d]", port), dut.events[port], exp_ev);
    endtask

    // Host requests of one port follow the burst address rule
    task automatic check_host_log(int port);
        host_chan_pkg::t_host_rd_req exp;
        logic [31:0] burst_bytes;
        int idx;
        idx = 0;
        exp.valid = 1'b1;
        exp.vchan = host_chan_pkg::t_vchan'(port);
        exp.addr = cmds[port].start_addr;
        exp.len = cmds[port].burst_len;
        burst_bytes = (32'(cmds[port].burst_len) + 32'd1) << 3;
        foreach (req_log[k])
        begin
            if (int'(req_log[k].vchan) == port)
            begin
                compare_host_req("host_rd_req", req_log[k], exp);
                exp.addr = exp.addr + burst_bytes;
                idx++;
            end
        end
        if (idx != int'(cmds[port].num_bursts))
            report_error($sformatf("port %0d sent %0d host requests instead of %0d",
                                   port, idx, cmds[port].num_bursts));
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        rst = 1'b1;
        host_req_credit = 1'b0;
        host_rd_rsp = '0;
        host_mmio_req = '0;
        hold_credits = 1'b0;
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
        begin
            req_total[p] = 0;
            beat_total[p] = 0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Instance number and tag on every vchan
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
            read_and_compare(p, host_chan_pkg::REG_ID, 64'(p));

        // One command on one port
        req_log.delete();
        start_run(1, make_cmd(32'h0000_1000, 5, 3));
        check_port(1);
        check_host_log(1);

        // All ports at once with data interleaved on the host channel
        req_log.delete();
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
            start_run(p, make_cmd(32'h0001_0000 * (p + 1) + 32'h40 * p, 3 + p, 3 * p + 1));
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
        begin
            check_port(p);
            check_host_log(p);
        end

        // Credits held back, so the mux must stall at the credit limit
        req_log.delete();
        hold_credits <= 1'b1;
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
            start_run(p, make_cmd(32'h0008_0000 + 32'h1000 * p, 4, 1));
        // A full window of owed credits means the host drained every request
        wait_cycles = 0;
        do
        begin
            @(negedge clk);
            wait_cycles++;
        end
        while (credit_owed < host_chan_pkg::HOST_REQ_CREDITS && wait_cycles < 200);
        if (credit_owed < host_chan_pkg::HOST_REQ_CREDITS)
            report_error("credits held but the host never drained a full window");
        @(posedge clk);
        hold_credits <= 1'b0;
        for (int p = 0; p < host_chan_pkg::NUM_AFU_PORTS; p++)
        begin
            check_port(p);
            check_host_log(p);
        end

        // Second start while busy is dropped
        req_log.delete();
        start_run(2, make_cmd(32'h0000_3000, 6, 7));
        mmio_write(2, host_chan_pkg::REG_CTRL, make_cmd(32'h0000_7000, 2, 0));
        check_port(2);
        check_host_log(2);

        if (dut.host_mem_mux.mux_asserts.fail_cnt != 0)
            report_error("a bound assertion on the mux failed");
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* host_chan_afu_top.f */
design/host_chan_pkg.sv
design/host_mem_vchan_mux.sv
design/mmio_vchan_demux.sv
design/read_event_counter.sv
design/afu_read_engine.sv
design/host_chan_afu_top.sv
verification/host_chan_afu_asserts.sv
verification/host_chan_afu_tb.sv
